// ==== all.f ====
source/cache_pkg.sv
source/cache_datapath.sv
source/eviction_buffer.sv
source/cache_controller.sv
source/eviction_buffered_cache.sv
bench/memory_model.sv
bench/cache_assertions.sv
bench/cache_tb.sv

// ==== bench/cache_assertions.sv ====
module cache_assertions (
    input logic                clk,
    input logic                reset,
    input cache_pkg::wb_req_t  cpu_req,
    input cache_pkg::wb_rsp_t  cpu_rsp,
    input cache_pkg::wb_req_t  mem_req,
    input cache_pkg::mem_rsp_t mem_rsp
);

    timeunit 1ns;
    timeprecision 1ps;

    cpu_stb_in_cycle: assert property (@(posedge clk) disable iff (reset)
        cpu_req.stb |-> cpu_req.cyc)
        else $error("processor stb outside a bus cycle");

    mem_stb_in_cycle: assert property (@(posedge clk) disable iff (reset)
        mem_req.stb |-> mem_req.cyc)
        else $error("memory stb outside a bus cycle");

    // Request held until the slave answers.
    mem_req_stable: assert property (@(posedge clk) disable iff (reset)
        (mem_req.stb && !mem_rsp.ack && !mem_rsp.rty) |=> $stable(mem_req))
        else $error("memory request changed before ack or rty");

    cpu_ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
        cpu_rsp.ack |-> (cpu_req.cyc && cpu_req.stb))
        else $error("processor ack without an active request");

    no_mem_cycle_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !mem_req.cyc)
        else $error("memory cycle in the first cycle after reset");

endmodule : cache_assertions

// ==== bench/cache_tb.sv ====
module cache_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import cache_pkg::*;

    localparam int WAIT_LIMIT = 300;                      // Cycles per transfer.

    logic     clk = 1'b0;
    logic     reset;
    logic     slow;
    logic     retry_on;
    int       rty_count;
    int       reads_checked;
    integer   seed = 32'h7001;
    wb_req_t  cpu_req;
    wb_rsp_t  cpu_rsp;
    wb_req_t  mem_req;
    mem_rsp_t mem_rsp;
    line_t    shadow [4096];                              // Expected memory image.
    line_t    expected_q [$];

    eviction_buffered_cache DUT (.clk, .reset, .cpu_req, .cpu_rsp, .mem_req, .mem_rsp);

    memory_model #(.SEED(32'h7001)) MEM (
        .clk, .reset, .slow, .retry_on, .mem_req, .mem_rsp, .rty_count
    );

    bind eviction_buffered_cache cache_assertions protocol_checks (
        .clk(clk),
        .reset(reset),
        .cpu_req(cpu_req),
        .cpu_rsp(cpu_rsp),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp)
    );

    always #5 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // Reference: selected bytes of a write replace the old line.
    function automatic line_t merge_bytes(line_t old_line, line_t wr_line, sel_t sel);
        line_t result;
        result = old_line;
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (sel[b]) begin
                result[8*b +: 8] = wr_line[8*b +: 8];
            end
        end
        return result;
    endfunction

    function automatic addr_t make_adr(int tag, int set);
        return {tag[TAG_BITS-1:0], set[INDEX_BITS-1:0], OFFSET_BITS'(0)};
    endfunction

    function automatic line_t random_line();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // One processor transfer; latency counts falling edges up to ack.
    task automatic cpu_access(input logic we, input addr_t adr, input sel_t sel,
                              input line_t dat, output int latency);
        int waited;
        cpu_req = '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, adr: adr, dat: dat};
        if (we) begin
            shadow[adr[ADDR_WIDTH-1:OFFSET_BITS]] =
                merge_bytes(shadow[adr[ADDR_WIDTH-1:OFFSET_BITS]], dat, sel);
        end else begin
            expected_q.push_back(shadow[adr[ADDR_WIDTH-1:OFFSET_BITS]]);
        end
        @(negedge clk);
        waited = 1;
        while (!cpu_rsp.ack && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (cpu_rsp.ack) else stop_with_failure("no processor ack within the timeout");
        latency = waited;
        @(negedge clk);                                   // Hold through the ack edge.
        cpu_req = '0;
    endtask

    task automatic read_at(input addr_t adr);
        int latency;
        cpu_access(1'b0, adr, '0, '0, latency);
    endtask

    task automatic write_at(input addr_t adr, input sel_t sel, input line_t dat);
        int latency;
        cpu_access(1'b1, adr, sel, dat, latency);
    endtask

    task automatic check_hit(input int latency);
        assert (latency == 2) else stop_with_failure(
            $sformatf("ERR cpu_rsp.ack latency expected %h actual %h", 2, latency));
    endtask

    // Compare process for every acknowledged read.
    always @(posedge clk) begin
        if (!reset && cpu_rsp.ack && !cpu_req.we) begin
            assert (expected_q.size() > 0) else stop_with_failure("read ack with no read pending");
            assert (cpu_rsp.dat == expected_q[0]) else stop_with_failure(
                $sformatf("ERR cpu_rsp.dat expected %h actual %h", expected_q[0], cpu_rsp.dat));
            void'(expected_q.pop_front());
            reads_checked++;
        end
    end

    initial begin
        int    latency;
        addr_t adr;
        cpu_req       = '0;
        slow          = 1'b0;
        retry_on      = 1'b0;
        reads_checked = 0;
        reset         = 1'b1;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < 4096; i++) begin
            shadow[i] = MEM.lines[i];
        end

        read_at(make_adr(1, 0));                          // Cold miss.
        cpu_access(1'b0, make_adr(1, 0), '0, '0, latency);
        check_hit(latency);

        cpu_access(1'b1, make_adr(1, 0), 16'h00F0, random_line(), latency);
        check_hit(latency);
        cpu_access(1'b1, make_adr(1, 0), 16'h8001, random_line(), latency);
        check_hit(latency);
        read_at(make_adr(1, 0));

        // Third tag in set 1 pushes out the oldest dirty line.
        write_at(make_adr(2, 1), '1, random_line());
        write_at(make_adr(3, 1), 16'h0F0F, random_line());
        write_at(make_adr(4, 1), '1, random_line());
        cpu_access(1'b0, make_adr(4, 1), '0, '0, latency);
        check_hit(latency);
        cpu_access(1'b0, make_adr(3, 1), '0, '0, latency);
        check_hit(latency);                               // Tag 2 was the victim.
        read_at(make_adr(2, 1));

        retry_on = 1'b1;
        for (int t = 5; t < 8; t++) begin
            write_at(make_adr(t, 2), 16'hA5A5, random_line());
        end
        for (int t = 5; t < 8; t++) begin
            read_at(make_adr(t, 2));
        end
        assert (rty_count > 0) else stop_with_failure("memory never answered with a retry");

        for (int i = 0; i < 150; i++) begin
            retry_on = (i >= 75);
            adr      = make_adr($random(seed) & 7, $random(seed) & 3);
            if (($random(seed) & 1) == 1) begin
                write_at(adr, sel_t'($random(seed)), random_line());
            end else begin
                read_at(adr);
            end
        end

        // Slow memory keeps the drain busy across the next hit.
        retry_on = 1'b0;
        slow     = 1'b1;
        write_at(make_adr(8, 3), '1, random_line());
        write_at(make_adr(9, 3), '1, random_line());
        read_at(make_adr(10, 3));
        cpu_access(1'b0, make_adr(9, 3), '0, '0, latency);
        check_hit(latency);
        assert (mem_req.cyc && mem_req.we) else stop_with_failure("drain ended before the hit");
        read_at(make_adr(8, 3));
        slow = 1'b0;

        if (expected_q.size() == 0 && reads_checked > 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            stop_with_failure("reads were left unchecked at the end of the run");
        end
    end

endmodule : cache_tb

// ==== bench/memory_model.sv ====
module memory_model #(
    parameter logic [31:0] SEED = 32'h7001
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                slow,                     // Fixed long ack delay.
    input  logic                retry_on,                 // Allow rty answers.
    input  cache_pkg::wb_req_t  mem_req,
    output cache_pkg::mem_rsp_t mem_rsp,
    output int                  rty_count
);

    timeunit 1ns;
    timeprecision 1ps;

    import cache_pkg::*;

    line_t  lines [4096];                                 // One entry per line address.
    integer seed = SEED;
    int     wait_left;
    logic   busy;

    function automatic line_t pattern(int unsigned line_adr);
        line_t result;
        for (int w = 0; w < 4; w++) begin
            result[32*w +: 32] = (line_adr * 32'h9E37_79B1) ^ (32'h0101_0101 * (w + 1));
        end
        return result;
    endfunction

    initial begin
        for (int i = 0; i < 4096; i++) begin
            lines[i] = pattern(i);
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            mem_rsp   <= '0;
            busy      <= 1'b0;
            wait_left <= 0;
            rty_count <= 0;
        end else if (mem_rsp.ack || mem_rsp.rty) begin
            mem_rsp.ack <= 1'b0;                          // Response lasts one cycle.
            mem_rsp.rty <= 1'b0;
        end else if (!(mem_req.cyc && mem_req.stb)) begin
            busy <= 1'b0;
        end else if (!busy) begin
            busy      <= 1'b1;
            wait_left <= slow ? 8 : ($random(seed) & 3);
        end else if (wait_left > 0) begin
            wait_left <= wait_left - 1;
        end else if (retry_on && (($random(seed) & 1) == 1)) begin
            busy        <= 1'b0;
            mem_rsp.rty <= 1'b1;                          // No data, master reissues.
            rty_count   <= rty_count + 1;
        end else begin
            busy        <= 1'b0;
            mem_rsp.ack <= 1'b1;
            if (mem_req.we) begin
                lines[mem_req.adr[ADDR_WIDTH-1:OFFSET_BITS]] <= mem_req.dat;
            end else begin
                mem_rsp.dat <= lines[mem_req.adr[ADDR_WIDTH-1:OFFSET_BITS]];
            end
        end
    end

endmodule : memory_model

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module cache_tb -f all.f -o cache_sim
./obj_dir/cache_sim

// ==== source/cache_controller.sv ====
module cache_controller (
    input  logic                clk,
    input  logic                reset,

    /* processor->controller */
    input  cache_pkg::wb_req_t  cpu_req,

    /* datapath->controller */
    input  logic                hit,
    input  logic                victim_dirty,

    /* eviction buffer and memory->controller */
    input  logic                evb_valid,
    input  cache_pkg::mem_rsp_t mem_rsp,

    /* controller->processor */
    output logic                cpu_ack,

    /* controller->datapath */
    output logic                way_load,
    output logic                fill_sel,
    output logic                lru_touch,
    output logic                victim_capture,

    /* controller->eviction buffer */
    output logic                evb_load,
    output logic                fetch
);

    import cache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;

    logic cpu_valid;
    logic fill_ok;
    logic may_start;

    assign cpu_valid = cpu_req.cyc & cpu_req.stb;
    assign fill_ok   = mem_rsp.ack & ~mem_rsp.rty;        // Rty does not end the fill.

    // A miss stays in IDLE while the buffer still holds a line.
    assign may_start = hit | ~evb_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        unique case (state)
            IDLE: begin
                if (cpu_valid && may_start) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    next_state = DONE;
                end else begin
                    next_state = FILL;
                end
            end
            FILL: begin
                if (fill_ok) begin
                    next_state = DONE;
                end
            end
            DONE: begin
                next_state = IDLE;                        // One ack per request.
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_comb begin
        cpu_ack        = 1'b0;
        way_load       = 1'b0;
        fill_sel       = 1'b0;
        lru_touch      = 1'b0;
        victim_capture = 1'b0;
        evb_load       = 1'b0;
        fetch          = 1'b0;
        unique case (state)
            IDLE: begin
            end
            LOOKUP: begin
                if (hit) begin
                    way_load = cpu_req.we;                // Write hit merges in place.
                end else begin
                    victim_capture = 1'b1;
                    evb_load       = victim_dirty;
                end
            end
            FILL: begin
                fetch = 1'b1;
                if (fill_ok) begin
                    way_load = 1'b1;
                    fill_sel = 1'b1;                      // Line comes from memory.
                end
            end
            DONE: begin
                // The requested line is resident here, so hit selects it.
                cpu_ack   = 1'b1;
                lru_touch = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule : cache_controller

// ==== source/cache_datapath.sv ====
module cache_datapath (
    input  logic               clk,
    input  logic               reset,

    /* processor and memory data */
    input  cache_pkg::wb_req_t cpu_req,
    input  cache_pkg::line_t   mem_dat,

    /* controller->datapath */
    input  logic               way_load,
    input  logic               fill_sel,
    input  logic               lru_touch,
    input  logic               victim_capture,

    /* datapath->controller */
    output logic               hit,
    output cache_pkg::way_t    hit_way,
    output logic               victim_dirty,

    /* datapath->eviction buffer */
    output cache_pkg::line_t   victim_line,
    output cache_pkg::addr_t   victim_adr,

    /* datapath->processor */
    output cache_pkg::line_t   rd_line
);

    import cache_pkg::*;

    // Tag and data stores, indexed [way][set].
    tag_t  tags [ASSOCIATIVITY][NUM_SETS];
    line_t data [ASSOCIATIVITY][NUM_SETS];

    logic [NUM_SETS-1:0][ASSOCIATIVITY-1:0] valid;
    logic [NUM_SETS-1:0][ASSOCIATIVITY-1:0] dirty;
    way_t [NUM_SETS-1:0]                    lru;          // Least recently used way per set.
    way_t                                   fill_way;     // Way picked for the pending fill.

    index_t index;
    tag_t   tag;
    way_t   lru_way;
    way_t   load_way;
    line_t  base_line;
    line_t  merged_line;

    assign index   = cpu_req.adr[OFFSET_BITS +: INDEX_BITS];
    assign tag     = cpu_req.adr[ADDR_WIDTH-1 -: TAG_BITS];
    assign lru_way = lru[index];

    // Parallel tag compare over all ways of the set.
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < ASSOCIATIVITY; w++) begin
            if (valid[index][w] && tags[w][index] == tag) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    assign rd_line = data[hit_way][index];

    // The LRU way is the victim of a miss.
    assign victim_dirty = valid[index][lru_way] & dirty[index][lru_way];
    assign victim_line  = data[lru_way][index];
    assign victim_adr   = {tags[lru_way][index], index, OFFSET_BITS'(0)};

    assign load_way  = fill_sel ? fill_way : hit_way;
    assign base_line = fill_sel ? mem_dat : rd_line;

    // Byte lanes from the processor replace the base line on writes.
    always_comb begin
        merged_line = base_line;
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (cpu_req.we && cpu_req.sel[b]) begin
                merged_line[8*b +: 8] = cpu_req.dat[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid    <= '0;
            dirty    <= '0;
            lru      <= '0;
            fill_way <= '0;
        end else begin
            if (victim_capture) begin
                fill_way                <= lru_way;
                valid[index][lru_way]   <= 1'b0;          // Copy now lives in the buffer.
                dirty[index][lru_way]   <= 1'b0;
            end
            if (way_load) begin
                valid[index][load_way] <= 1'b1;
                if (fill_sel) begin
                    dirty[index][load_way] <= cpu_req.we; // Fresh line from memory.
                end else begin
                    dirty[index][load_way] <= dirty[index][load_way] | cpu_req.we;
                end
            end
            if (lru_touch) begin
                lru[index] <= ~hit_way;                   // Other way of the pair.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (way_load) begin
            data[load_way][index] <= merged_line;
            tags[load_way][index] <= tag;
        end
    end

endmodule : cache_datapath

// ==== source/cache_pkg.sv ====
package cache_pkg;

    localparam int NUM_LINES     = 8;
    localparam int ASSOCIATIVITY = 2;                     // Two ways per set.
    localparam int NUM_SETS      = NUM_LINES / ASSOCIATIVITY;

    localparam int ADDR_WIDTH  = 16;                      // Byte address.
    localparam int LINE_BYTES  = 16;
    localparam int OFFSET_BITS = $clog2(LINE_BYTES);
    localparam int INDEX_BITS  = $clog2(NUM_SETS);
    localparam int TAG_BITS    = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS;

    typedef logic [ADDR_WIDTH-1:0]            addr_t;
    typedef logic [8*LINE_BYTES-1:0]          line_t;
    typedef logic [LINE_BYTES-1:0]            sel_t;
    typedef logic [TAG_BITS-1:0]              tag_t;
    typedef logic [INDEX_BITS-1:0]            index_t;
    typedef logic [$clog2(ASSOCIATIVITY)-1:0] way_t;

    // Master request, used on both buses.
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        sel_t  sel;
        addr_t adr;
        line_t dat;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        line_t dat;
    } wb_rsp_t;

    typedef struct packed {
        logic  ack;
        logic  rty;                                       // Reissue the same cycle.
        line_t dat;
    } mem_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        FILL,
        DONE
    } ctrl_state_t;

endpackage : cache_pkg

// ==== source/eviction_buffer.sv ====
module eviction_buffer (
    input  logic                clk,
    input  logic                reset,

    /* datapath and controller->buffer */
    input  logic                evb_load,
    input  cache_pkg::line_t    victim_line,
    input  cache_pkg::addr_t    victim_adr,
    input  logic                fetch,
    input  cache_pkg::addr_t    fetch_adr,

    /* memory->buffer */
    input  cache_pkg::mem_rsp_t mem_rsp,

    /* OUTPUTS */
    output logic                evb_valid,
    output cache_pkg::wb_req_t  mem_req
);

    import cache_pkg::*;

    line_t evb_line;
    addr_t evb_adr;
    logic  drain_done;

    // A drain only completes when it owns the bus.
    assign drain_done = evb_valid && !fetch && mem_rsp.ack && !mem_rsp.rty;

    always_ff @(posedge clk) begin
        if (reset) begin
            evb_valid <= 1'b0;
        end else if (evb_load) begin
            evb_valid <= 1'b1;
        end else if (drain_done) begin
            evb_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (evb_load) begin
            evb_line <= victim_line;
            evb_adr  <= victim_adr;
        end
    end

    // Fill has priority; the drain waits for the bus.
    always_comb begin
        mem_req = '0;
        if (fetch) begin
            mem_req.cyc = 1'b1;
            mem_req.stb = 1'b1;
            mem_req.we  = 1'b0;
            mem_req.sel = '1;
            mem_req.adr = {fetch_adr[ADDR_WIDTH-1:OFFSET_BITS], OFFSET_BITS'(0)};
        end else if (evb_valid) begin
            mem_req.cyc = 1'b1;                           // Held through rty.
            mem_req.stb = 1'b1;
            mem_req.we  = 1'b1;
            mem_req.sel = '1;
            mem_req.adr = evb_adr;
            mem_req.dat = evb_line;
        end
    end

endmodule : eviction_buffer

// ==== source/eviction_buffered_cache.sv ====
module eviction_buffered_cache (
    input  logic                clk,
    input  logic                reset,

    /* processor side */
    input  cache_pkg::wb_req_t  cpu_req,
    output cache_pkg::wb_rsp_t  cpu_rsp,

    /* memory side */
    output cache_pkg::wb_req_t  mem_req,
    input  cache_pkg::mem_rsp_t mem_rsp
);

    import cache_pkg::*;

    logic  way_load;
    logic  fill_sel;
    logic  lru_touch;
    logic  victim_capture;
    logic  hit;
    logic  victim_dirty;
    line_t victim_line;
    addr_t victim_adr;
    line_t rd_line;
    logic  evb_load;
    logic  evb_valid;
    logic  fetch;
    logic  cpu_ack;

    assign cpu_rsp.ack = cpu_ack;
    assign cpu_rsp.dat = rd_line;

    cache_datapath _cache_datapath (
        .clk,
        .reset,
        .cpu_req,
        .mem_dat(mem_rsp.dat),
        .way_load,
        .fill_sel,
        .lru_touch,
        .victim_capture,
        .hit,
        .hit_way(),
        .victim_dirty,
        .victim_line,
        .victim_adr,
        .rd_line
    );

    eviction_buffer _eviction_buffer (
        .clk,
        .reset,
        .evb_load,
        .victim_line,
        .victim_adr,
        .fetch,
        .fetch_adr(cpu_req.adr),                          // Miss address.
        .mem_rsp,
        .evb_valid,
        .mem_req
    );

    cache_controller _cache_controller (
        .clk,
        .reset,
        .cpu_req,
        .hit,
        .victim_dirty,
        .evb_valid,
        .mem_rsp,
        .cpu_ack,
        .way_load,
        .fill_sel,
        .lru_touch,
        .victim_capture,
        .evb_load,
        .fetch
    );

endmodule : eviction_buffered_cache
